/* source/cen_gen_defs.svh */
// shared widths, window length and register map of the clock-enable generator, include where needed
`ifndef CEN_GEN_DEFS_SVH
`define CEN_GEN_DEFS_SVH

`define CEN_CHANNELS 2      // independent enable channels
`define CEN_FRAC_W   10     // width of n and m
`define CEN_DIV_W    2      // base enable plus halvings
`define CEN_CNT_W    16     // tally width
`define CEN_WINDOW   1000   // measurement length in clocks
`define CEN_ADDR_W   8      // axi byte address width

// register map, ratio and count repeat per channel
`define CEN_REG_CTRL   8'h00
`define CEN_REG_STATUS 8'h04
`define CEN_REG_RATIO0 8'h08
`define CEN_REG_COUNT0 8'h0C
`define CEN_REG_STRIDE 8

`define CEN_RESP_OKAY   2'b00
`define CEN_RESP_SLVERR 2'b10
`endif

/* source/cen_gen_pkg.sv */
// types shared by the clock-enable generator RTL and its testbench, import with cen_gen_pkg::*
`include "cen_gen_defs.svh"

package cen_gen_pkg;

    typedef logic [`CEN_FRAC_W-1:0] frac_t;  // numerator or denominator
    typedef logic [`CEN_DIV_W-1:0]  cen_t;   // bit 0 base rate, bit 1 halved
    typedef logic [`CEN_CNT_W-1:0]  tally_t; // pulses seen in one window

    typedef struct packed {
        frac_t m;  // denominator
        frac_t n;  // numerator, n <= m
    } ratio_t;

    // master to slave half of the register bus
    typedef struct packed {
        logic [`CEN_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [`CEN_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_m2s_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_s2m_t;

    typedef enum logic [1:0] {st_idle, st_restart, st_measure, st_latch} meas_state_t;

endpackage

/* source/cen_ctrl.sv */
// AXI4-Lite register block and measurement FSM, one instance inside cen_gen_top
`include "cen_gen_defs.svh"

module cen_ctrl
    import cen_gen_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  axil_m2s_t                  axil_req,
    output axil_s2m_t                  axil_rsp,
    output ratio_t [`CEN_CHANNELS-1:0] ratio,
    output logic                       restart,
    output logic                       gate,
    input  tally_t [`CEN_CHANNELS-1:0] cen_tally,
    input  tally_t [`CEN_CHANNELS-1:0] cenb_tally
);
    localparam int WIN_W = $clog2(`CEN_WINDOW + 1);

    meas_state_t      state;
    logic [WIN_W-1:0] win_cnt;   // 0 is the settle cycle, 1..window is gated
    logic             done;
    logic             err;       // sticky, refused ratio write
    logic             busy;

    logic        bvalid;
    logic [1:0]  bresp;
    logic        rvalid;
    logic [31:0] rdata;
    logic        wr_accept;
    logic        rd_accept;
    logic [31:0] wmask;          // byte strobes widened to bits
    logic        start_req;
    logic        clr_err;
    logic [31:0] rd_word;

    logic   [`CEN_CHANNELS-1:0] ratio_sel;
    logic   [`CEN_CHANNELS-1:0] ratio_ok;
    ratio_t [`CEN_CHANNELS-1:0] ratio_new;

    function automatic logic [`CEN_ADDR_W-1:0] ratio_addr(int ch);
        return `CEN_ADDR_W'(`CEN_REG_RATIO0 + ch * `CEN_REG_STRIDE);
    endfunction

    function automatic logic [`CEN_ADDR_W-1:0] count_addr(int ch);
        return `CEN_ADDR_W'(`CEN_REG_COUNT0 + ch * `CEN_REG_STRIDE);
    endfunction

    // n in 9:0, m in 25:16
    function automatic logic [31:0] ratio_word(ratio_t r);
        logic [31:0] w;
        w = '0;
        w[`CEN_FRAC_W-1:0] = r.n;
        w[16 +: `CEN_FRAC_W] = r.m;
        return w;
    endfunction

    assign busy    = state != st_idle;
    assign restart = state == st_restart;
    assign gate    = (state == st_measure) && (win_cnt != '0);

    // write decode
    always_comb begin
        wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid; // one response in flight
        for (int b = 0; b < 4; b++) begin
            wmask[8*b +: 8] = {8{axil_req.wstrb[b]}};
        end
        start_req = wr_accept && (axil_req.awaddr == `CEN_REG_CTRL)
                    && axil_req.wstrb[0] && axil_req.wdata[0];
        clr_err   = wr_accept && (axil_req.awaddr == `CEN_REG_STATUS)
                    && axil_req.wstrb[0] && axil_req.wdata[2];
        for (int i = 0; i < `CEN_CHANNELS; i++) begin
            ratio_sel[i]   = axil_req.awaddr == ratio_addr(i);
            // merge strobed bytes over the current value
            ratio_new[i].n = (ratio[i].n & ~wmask[`CEN_FRAC_W-1:0])
                             | (axil_req.wdata[`CEN_FRAC_W-1:0] & wmask[`CEN_FRAC_W-1:0]);
            ratio_new[i].m = (ratio[i].m & ~wmask[16 +: `CEN_FRAC_W])
                             | (axil_req.wdata[16 +: `CEN_FRAC_W] & wmask[16 +: `CEN_FRAC_W]);
            // legal ratio and no window running
            ratio_ok[i]    = (ratio_new[i].m != '0) && (ratio_new[i].n <= ratio_new[i].m)
                             && !busy;
        end
    end

    // read decode
    always_comb begin
        rd_accept = axil_req.arvalid && !rvalid;
        rd_word   = '0;  // ctrl and unmapped read as zero
        if (axil_req.araddr == `CEN_REG_STATUS) begin
            rd_word[2:0] = {err, done, busy};
        end
        for (int i = 0; i < `CEN_CHANNELS; i++) begin
            if (axil_req.araddr == ratio_addr(i)) begin
                rd_word = ratio_word(ratio[i]);
            end
            if (axil_req.araddr == count_addr(i)) begin
                rd_word = {cenb_tally[i], cen_tally[i]};
            end
        end
    end

    // write channel, ratio registers and sticky error
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
            err    <= 1'b0;
            for (int i = 0; i < `CEN_CHANNELS; i++) begin
                ratio[i] <= '{n: frac_t'(1), m: frac_t'(2)}; // half rate default
            end
        end else begin
            if (bvalid && axil_req.bready) bvalid <= 1'b0;
            if (wr_accept) begin
                bvalid <= 1'b1;
                for (int i = 0; i < `CEN_CHANNELS; i++) begin
                    if (ratio_sel[i] && ratio_ok[i]) ratio[i] <= ratio_new[i];
                    if (ratio_sel[i] && !ratio_ok[i]) err <= 1'b1;
                end
                if (clr_err) err <= 1'b0;
            end
        end
    end

    // response code, valid only with bvalid
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= ((ratio_sel & ~ratio_ok) != '0) ? `CEN_RESP_SLVERR : `CEN_RESP_OKAY;
        end
    end

    // read channel
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rdata <= rd_word; // held until rready
    end

    // measurement FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            win_cnt <= '0;
            done    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_req) begin
                        state <= st_restart;
                        done  <= 1'b0;
                    end
                end
                st_restart: begin
                    state   <= st_measure;
                    win_cnt <= '0;
                end
                st_measure: begin
                    win_cnt <= win_cnt + 1'b1;
                    if (win_cnt == WIN_W'(`CEN_WINDOW)) state <= st_latch;
                end
                default: begin  // st_latch, tallies copy out this cycle
                    state <= st_idle;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = !rvalid;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = `CEN_RESP_OKAY;
    end

endmodule

/* source/frac_cen.sv */
// fractional n/m clock-enable accumulator for one channel, instanced per channel by cen_gen_top
`include "cen_gen_defs.svh"

module frac_cen
    import cen_gen_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   restart,   // clears accumulator and edge counters
    input  ratio_t ratio,
    output cen_t   cen,
    output cen_t   cenb       // 180 degree shifted
);
    localparam int AW = `CEN_FRAC_W + 1;  // one spare bit for acc + n

    logic [AW-1:0] step;
    logic [AW-1:0] lim;
    logic [AW-1:0] absmax;    // acc never legally reaches n+m
    logic [AW-1:0] acc;
    logic [AW-1:0] acc_add;
    logic [AW-1:0] acc_wrap;
    logic          half;      // cenb already fired this period
    logic          over;
    logic          halfway;

    cen_t edge_cnt;
    cen_t edge_cnt_b;
    cen_t edge_nxt;
    cen_t edge_nxt_b;
    cen_t toggle;             // carry pattern gives the halvings
    cen_t toggle_b;

    always_comb begin
        step     = {1'b0, ratio.n};
        lim      = {1'b0, ratio.m};
        absmax   = lim + step;
        acc_add  = acc + step;
        acc_wrap = acc_add - lim;
        over     = acc_add >= lim;
        halfway  = (acc_add >= (lim >> 1)) && !half;
        edge_nxt   = edge_cnt + 1'b1;
        edge_nxt_b = edge_cnt_b + 1'b1;
        toggle     = edge_nxt & ~edge_cnt;
        toggle_b   = edge_nxt_b & ~edge_cnt_b;
    end

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            acc        <= '0;
            half       <= 1'b0;
            edge_cnt   <= '0;
            edge_cnt_b <= '0;
            cen        <= '0;
            cenb       <= '0;
        end else begin
            cen  <= '0;  // single cycle pulses
            cenb <= '0;
            if (acc >= absmax) begin
                acc <= '0;  // out of range after a ratio change
            end else begin
                if (halfway) begin
                    half       <= 1'b1;
                    edge_cnt_b <= edge_nxt_b;
                    cenb       <= {toggle_b[`CEN_DIV_W-2:0], 1'b1};
                end
                if (over) begin
                    acc      <= acc_wrap;
                    half     <= 1'b0;  // new period, wins over halfway
                    edge_cnt <= edge_nxt;
                    cen      <= {toggle[`CEN_DIV_W-2:0], 1'b1};
                end else begin
                    acc <= acc_add;
                end
            end
        end
    end

endmodule

/* source/cen_tally.sv */
// pulse counters of one channel over the measurement window, instanced per channel by cen_gen_top
`include "cen_gen_defs.svh"

module cen_tally
    import cen_gen_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   restart,
    input  logic   gate,        // high for the whole window
    input  logic   cen_pulse,
    input  logic   cenb_pulse,
    output tally_t cen_count,   // last finished window
    output tally_t cenb_count
);
    tally_t run_cen;   // running counts
    tally_t run_cenb;
    logic   gate_d;
    logic   gate_fall;

    assign gate_fall = gate_d && !gate;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_cen    <= '0;
            run_cenb   <= '0;
            gate_d     <= 1'b0;
            cen_count  <= '0;
            cenb_count <= '0;
        end else begin
            gate_d <= gate;
            if (restart) begin
                run_cen  <= '0;
                run_cenb <= '0;
            end else if (gate) begin
                if (cen_pulse)  run_cen  <= run_cen + 1'b1;
                if (cenb_pulse) run_cenb <= run_cenb + 1'b1;
            end
            // outputs hold through the next window
            if (gate_fall) begin
                cen_count  <= run_cen;
                cenb_count <= run_cenb;
            end
        end
    end

endmodule

/* source/cen_gen_top.sv */
// top of the clock-enable generator, AXI4-Lite control plus per-channel enable datapaths
`include "cen_gen_defs.svh"

module cen_gen_top
    import cen_gen_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  axil_m2s_t                axil_req,
    output axil_s2m_t                axil_rsp,
    output cen_t [`CEN_CHANNELS-1:0] cen,
    output cen_t [`CEN_CHANNELS-1:0] cenb
);
    ratio_t [`CEN_CHANNELS-1:0] ratio;
    tally_t [`CEN_CHANNELS-1:0] cen_cnt;
    tally_t [`CEN_CHANNELS-1:0] cenb_cnt;
    logic                       restart;  // shared by all channels
    logic                       gate;

    cen_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .ratio      (ratio),
        .restart    (restart),
        .gate       (gate),
        .cen_tally  (cen_cnt),
        .cenb_tally (cenb_cnt)
    );

    for (genvar i = 0; i < `CEN_CHANNELS; i++) begin : g_ch
        frac_cen u_frac (
            .clk     (clk),
            .reset   (reset),
            .restart (restart),
            .ratio   (ratio[i]),
            .cen     (cen[i]),
            .cenb    (cenb[i])
        );

        // only the base rate is tallied
        cen_tally u_tally (
            .clk        (clk),
            .reset      (reset),
            .restart    (restart),
            .gate       (gate),
            .cen_pulse  (cen[i][0]),
            .cenb_pulse (cenb[i][0]),
            .cen_count  (cen_cnt[i]),
            .cenb_count (cenb_cnt[i])
        );
    end

endmodule

/* dv/cen_gen_checker.sv */
// monitor and scoreboard beside cen_gen_top, compares bus responses and the halved enables
`include "cen_gen_defs.svh"

module cen_gen_checker
    import cen_gen_pkg::*;
(
    input logic                     clk,
    input logic                     reset,
    input axil_m2s_t                axil_req,
    input axil_s2m_t                axil_rsp,
    input cen_t [`CEN_CHANNELS-1:0] cen,
    input cen_t [`CEN_CHANNELS-1:0] cenb
);
    timeunit 1ns;
    timeprecision 100ps;

    // expected read results, one entry per outstanding read
    string       rd_name_q [$];
    logic [31:0] rd_data_q [$];
    logic [31:0] rd_mask_q [$];   // bits compared exactly
    logic        rd_count_q [$];  // count word, cenb half may be off by one
    string       wr_name_q [$];
    logic [1:0]  wr_resp_q [$];

    string cur_name = "startup";
    int    errors;
    int    errors_at_open;
    int    tests_ok;
    int    tests_bad;
    int    aw_cnt;                   // accepted writes
    int    b_cnt;                    // write responses taken
    int    ar_cnt;
    int    r_cnt;
    int    pulses_a [`CEN_CHANNELS]; // cen bit 0 pulses since restart
    int    pulses_b [`CEN_CHANNELS];
    logic  restart_due;              // start accepted, DUT clears on the next edge

    task automatic open_test(string name);
        cur_name       = name;
        errors_at_open = errors;
    endtask

    task automatic close_test();
        if (errors == errors_at_open) begin
            tests_ok++;
            $display("test %s: pass", cur_name);
        end else begin
            tests_bad++;
            $display("test %s: fail with %0d errors", cur_name, errors - errors_at_open);
        end
    endtask

    task automatic expect_read(string name, logic [31:0] data, logic [31:0] mask, logic count);
        rd_name_q.push_back(name);
        rd_data_q.push_back(data);
        rd_mask_q.push_back(mask);
        rd_count_q.push_back(count);
    endtask

    task automatic expect_write(string name, logic [1:0] resp);
        wr_name_q.push_back(name);
        wr_resp_q.push_back(resp);
    endtask

    task automatic check_read();
        string       name;
        logic [31:0] exp;
        logic [31:0] mask;
        logic        count;
        logic        ok;
        int          diff;
        if (rd_data_q.size() == 0) begin
            errors++;
            $display("a read response came back with no read outstanding");
        end else begin
            name  = rd_name_q.pop_front();
            exp   = rd_data_q.pop_front();
            mask  = rd_mask_q.pop_front();
            count = rd_count_q.pop_front();
            if (count) begin
                diff = int'(axil_rsp.rdata[31:16]) - int'(exp[31:16]);
                ok   = (axil_rsp.rdata[15:0] === exp[15:0]) && diff >= -1 && diff <= 1;
            end else begin
                ok = ((axil_rsp.rdata ^ exp) & mask) === 32'd0;
            end
            if (!ok || axil_rsp.rresp !== `CEN_RESP_OKAY) begin
                errors++;
                $display("Error %s: expected 0x%08h actual 0x%08h rresp %0d",
                         name, exp, axil_rsp.rdata, axil_rsp.rresp);
            end
        end
    endtask

    task automatic check_write();
        string      name;
        logic [1:0] exp;
        if (wr_resp_q.size() == 0) begin
            errors++;
            $display("a write response came back with no write outstanding");
        end else begin
            name = wr_name_q.pop_front();
            exp  = wr_resp_q.pop_front();
            if (axil_rsp.bresp !== exp) begin
                errors++;
                $display("Error %s: expected bresp %0d actual %0d", name, exp, axil_rsp.bresp);
            end
        end
    endtask

    // halved copy marks pulses 1, 3, 5 and so on after restart
    function automatic logic halved_exp(cen_t e, int cnt);
        return e[0] && (cnt % 2 == 0);
    endfunction

    task automatic flag_halved(string which, int ch, logic exp, logic act);
        errors++;
        $display("Error %s: %s ch %0d bit 1 expected %0b actual %0b",
                 cur_name, which, ch, exp, act);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            restart_due = 1'b0;
            for (int c = 0; c < `CEN_CHANNELS; c++) begin
                pulses_a[c] = 0;
                pulses_b[c] = 0;
            end
        end else begin
            for (int c = 0; c < `CEN_CHANNELS; c++) begin
                if (cen[c][1] !== halved_exp(cen[c], pulses_a[c]))
                    flag_halved("cen", c, halved_exp(cen[c], pulses_a[c]), cen[c][1]);
                if (cenb[c][1] !== halved_exp(cenb[c], pulses_b[c]))
                    flag_halved("cenb", c, halved_exp(cenb[c], pulses_b[c]), cenb[c][1]);
                if (cen[c][0]) pulses_a[c]++;
                if (cenb[c][0]) pulses_b[c]++;
                if (restart_due) begin  // edge counters cleared in the DUT this edge
                    pulses_a[c] = 0;
                    pulses_b[c] = 0;
                end
            end
            restart_due = axil_req.awvalid && axil_rsp.awready
                          && axil_req.awaddr == `CEN_REG_CTRL
                          && axil_req.wstrb[0] && axil_req.wdata[0];
            // address and data are taken in the same cycle
            if (axil_rsp.awready !== axil_rsp.wready) begin
                errors++;
                $display("awready and wready were not raised together in test %s", cur_name);
            end
            if (axil_req.awvalid && axil_rsp.awready) aw_cnt++;
            if (axil_rsp.bvalid && axil_req.bready) begin
                b_cnt++;
                check_write();
            end
            if (axil_req.arvalid && axil_rsp.arready) ar_cnt++;
            if (axil_rsp.rvalid && axil_req.rready) begin
                r_cnt++;
                check_read();
            end
        end
    end

    task automatic report();
        if (aw_cnt != b_cnt) begin
            errors++;
            $display("%0d writes were accepted but %0d responses came back", aw_cnt, b_cnt);
        end
        if (ar_cnt != r_cnt) begin
            errors++;
            $display("%0d reads were accepted but %0d responses came back", ar_cnt, r_cnt);
        end
        if (rd_data_q.size() != 0 || wr_resp_q.size() != 0) begin
            errors++;
            $display("responses were still expected when the run ended");
        end
        $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    endtask

endmodule

/* dv/cen_gen_tb.sv */
// top testbench for cen_gen_top, runs a table of ratio writes and measurements over AXI4-Lite
`include "cen_gen_defs.svh"

module cen_gen_tb
    import cen_gen_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS     = 9;
    localparam int HS_MAX   = 64;    // cycles allowed for one handshake
    localparam int POLL_MAX = 1000;  // status reads while waiting for done

    typedef struct packed {
        int    ch;
        frac_t n;
        frac_t m;
        logic  refuse;   // write must come back SLVERR
        logic  measure;  // run a window in this row
    } row_t;

    string row_name [ROWS] = '{"rate_1_1", "rate_1_2", "rate_3_7", "rate_5_1023",
                               "rate_511_512", "zero_m", "n_over_m", "busy_write", "rate_2_3"};
    row_t  rows [ROWS] = '{
        '{0, 10'd1,   10'd1,    1'b0, 1'b1},
        '{1, 10'd1,   10'd2,    1'b0, 1'b1},
        '{0, 10'd3,   10'd7,    1'b0, 1'b1},
        '{1, 10'd5,   10'd1023, 1'b0, 1'b1},
        '{0, 10'd511, 10'd512,  1'b0, 1'b1},
        '{1, 10'd4,   10'd0,    1'b1, 1'b0},
        '{0, 10'd9,   10'd8,    1'b1, 1'b0},
        '{1, 10'd2,   10'd3,    1'b1, 1'b1},  // written while the window runs
        '{1, 10'd2,   10'd3,    1'b0, 1'b1}
    };

    logic                     clk;
    logic                     reset;
    axil_m2s_t                req;
    axil_s2m_t                rsp;
    cen_t [`CEN_CHANNELS-1:0] cen;
    cen_t [`CEN_CHANNELS-1:0] cenb;
    logic [31:0]              lfsr;
    frac_t                    mod_n [`CEN_CHANNELS];  // ratios the DUT should hold
    frac_t                    mod_m [`CEN_CHANNELS];
    logic                     mod_err;
    logic                     mod_done;

    cen_gen_top cen_gen_top_i (
        .clk      (clk),
        .reset    (reset),
        .axil_req (req),
        .axil_rsp (rsp),
        .cen      (cen),
        .cenb     (cenb)
    );

    cen_gen_checker chk (
        .clk      (clk),
        .reset    (reset),
        .axil_req (req),
        .axil_rsp (rsp),
        .cen      (cen),
        .cenb     (cenb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`CEN_ADDR_W-1:0] reg_ratio(int ch);
        return `CEN_ADDR_W'(`CEN_REG_RATIO0 + ch * `CEN_REG_STRIDE);
    endfunction

    function automatic logic [`CEN_ADDR_W-1:0] reg_count(int ch);
        return `CEN_ADDR_W'(`CEN_REG_COUNT0 + ch * `CEN_REG_STRIDE);
    endfunction

    function automatic logic [31:0] pack_ratio(frac_t n, frac_t m);
        return {6'd0, m, 6'd0, n};
    endfunction

    // floor(window * n / m) in both halves, cenb is compared within one
    function automatic logic [31:0] count_word(frac_t n, frac_t m);
        int pulses;
        pulses = (`CEN_WINDOW * int'(n)) / int'(m);
        return {pulses[15:0], pulses[15:0]};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort(string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // 0 to 3 idle cycles, two lfsr bits
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
        end
        repeat (gap) @(posedge clk);
    endtask

    task automatic reg_write(string name, logic [7:0] addr, logic [31:0] data,
                             logic [1:0] resp);
        int t;
        chk.expect_write(name, resp);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
        req.wvalid  <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rsp.awready && t < HS_MAX);
        if (!rsp.awready) abort("write address and data were never accepted");
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        idle_gap();
        req.bready <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rsp.bvalid && t < HS_MAX);
        if (!rsp.bvalid) abort("write response never arrived");
        req.bready <= 1'b0;
    endtask

    task automatic reg_read(string name, logic [7:0] addr, logic [31:0] exp,
                            logic [31:0] mask, logic count, output logic [31:0] data);
        int t;
        chk.expect_read(name, exp, mask, count);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rsp.arready && t < HS_MAX);
        if (!rsp.arready) abort("read address was never accepted");
        req.arvalid <= 1'b0;
        idle_gap();
        req.rready <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rsp.rvalid && t < HS_MAX);
        if (!rsp.rvalid) abort("read data never arrived");
        data = rsp.rdata;  // only steers polling
        req.rready <= 1'b0;
    endtask

    task automatic check_reg(string name, logic [7:0] addr, logic [31:0] exp);
        logic [31:0] data;
        reg_read(name, addr, exp, '1, 1'b0, data);
    endtask

    task automatic start_window(string name);
        reg_write(name, `CEN_REG_CTRL, 32'd1, `CEN_RESP_OKAY);
        mod_done = 1'b0;
    endtask

    task automatic wait_done(string name);
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_MAX) begin
            // busy and done move, only err and the unused bits are fixed
            reg_read(name, `CEN_REG_STATUS, {29'd0, mod_err, 2'b00}, 32'hffff_fffc, 1'b0,
                     status);
            polls++;
        end
        if (!status[1]) abort("measurement never finished, done stayed low");
        mod_done = 1'b1;
    endtask

    task automatic check_defaults();
        chk.open_test("reset_defaults");
        for (int c = 0; c < `CEN_CHANNELS; c++) begin
            check_reg("reset_defaults", reg_ratio(c), pack_ratio(frac_t'(1), frac_t'(2)));
        end
        check_reg("reset_defaults", `CEN_REG_STATUS, 32'd0);
        @(posedge clk);  // let the checker take the last response
        chk.close_test();
    endtask

    task automatic run_row(int i);
        row_t  r;
        string name;
        r    = rows[i];
        name = row_name[i];
        chk.open_test(name);
        if (r.measure && r.refuse) start_window(name);  // makes the ratio write land in busy
        reg_write(name, reg_ratio(r.ch), pack_ratio(r.n, r.m),
                  r.refuse ? `CEN_RESP_SLVERR : `CEN_RESP_OKAY);
        if (r.refuse) begin
            mod_err = 1'b1;
        end else begin
            mod_n[r.ch] = r.n;
            mod_m[r.ch] = r.m;
        end
        check_reg(name, reg_ratio(r.ch), pack_ratio(mod_n[r.ch], mod_m[r.ch]));
        if (r.measure) begin
            if (!r.refuse) start_window(name);
            wait_done(name);
            for (int c = 0; c < `CEN_CHANNELS; c++) begin
                check_count(name, c);
            end
        end
        check_reg(name, `CEN_REG_STATUS, {29'd0, mod_err, mod_done, 1'b0});
        if (mod_err) begin
            reg_write(name, `CEN_REG_STATUS, 32'h4, `CEN_RESP_OKAY);  // clear sticky error
            mod_err = 1'b0;
            check_reg(name, `CEN_REG_STATUS, {29'd0, mod_err, mod_done, 1'b0});
        end
        @(posedge clk);
        chk.close_test();
    endtask

    task automatic check_count(string name, int c);
        logic [31:0] data;
        reg_read(name, reg_count(c), count_word(mod_n[c], mod_m[c]), '1, 1'b1, data);
    endtask

    initial begin
        req      = '0;
        reset    = 1'b1;
        lfsr     = 32'h4bf6_ee0d;
        mod_err  = 1'b0;
        mod_done = 1'b0;
        for (int c = 0; c < `CEN_CHANNELS; c++) begin
            mod_n[c] = frac_t'(1);  // reset ratio 1/2
            mod_m[c] = frac_t'(2);
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_defaults();
        for (int i = 0; i < ROWS; i++) begin
            run_row(i);
        end
        chk.report();
        if (chk.errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* cen_gen.f */
+incdir+source
source/cen_gen_pkg.sv
source/cen_ctrl.sv
source/frac_cen.sv
source/cen_tally.sv
source/cen_gen_top.sv
dv/cen_gen_checker.sv
dv/cen_gen_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, exit status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f cen_gen.f --top-module cen_gen_tb &&
./obj_dir/Vcen_gen_tb | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
